/* logic/sprites.hex */
// Invader pattern, words 0 to 15, one row of 16 dots per word, bit 15 leftmost
0000
0180
03C0
07E0
0FF0
1DB8
3FFC
3FFC
0FF0
0C30
1818
300C
0000
0000
0000
0000
// Player pattern, words 16 to 31
0180
0180
03C0
03C0
07E0
07E0
3FFC
7FFE
7FFE
7FFE
FFFF
FFFF
FFFF
0000
0000
0000

/* test/game_cases.txt */
# Columns: F mask | R count mask | P x y rgb | S sound | C colour
# x, y and count are decimal, the rest hex; mask bit 0 left, bit 1 right, bit 2 fire
C e0
# Reset state, formation at 128, player at 320
P 144 70 e0
P 137 70 48
P 138 70 e0
P 700 10 00
P 320 436 e0
S 0
# Five frames to the left, formation follows one pixel per frame
R 5 1
P 315 436 e0
P 314 436 48
P 133 70 e0
P 132 70 48
R 2 2
P 317 436 e0
P 316 436 48
# Both buttons held, right wins
F 3
P 318 436 e0
P 317 436 48
# First shot leaves the muzzle at 332,408
F 4
P 332 408 e0
P 335 411 e0
P 336 408 48
P 332 412 48
S 0
F 0
P 332 404 e0
P 332 408 48
# Fire while the bullet flies launches nothing
F 4
P 332 400 e0
P 332 408 48
R 61 0
P 332 156 e0
P 66 70 e0
P 65 70 48
# Bullet enters row 2 and wounds invader 2,8
F 0
P 332 156 48
P 327 134 3c
P 295 134 e0
S 2
# Step left to aim, then fire while stepping
R 24 1
F 5
P 307 408 e0
S 0
R 30 2
# Formation has reached the left edge
P 10 70 e0
P 9 70 48
F 2
P 10 70 e0
P 9 70 48
F 2
P 11 70 e0
P 10 70 48
R 31 2
P 307 156 e0
# Second hit kills invader 2,8
F 2
P 305 134 48
P 337 134 e0
P 273 134 e0
P 305 102 e0
S 3
F 6
S 0
R 71 0
P 372 124 e0
# Third shot crosses the dead cell and wounds invader 1,8
F 0
P 378 102 3c
P 378 134 48
P 410 134 e0
S 2
C 1f
P 410 134 1f
P 358 436 1f
P 378 102 3c

/* sources.f */
logic/invaders_pkg.sv
logic/sprite_rom.sv
logic/player_ship.sv
logic/bullet_unit.sv
logic/invader_formation.sv
logic/pixel_renderer.sv
logic/invaders_top.sv
test/invaders_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module invaders_tb -o invaders_sim

# The simulator stops with an error status on failure, the log decides the result
./obj_dir/invaders_sim > sim.log 2>&1 || true
cat sim.log

if grep -q -x "All tests passed" sim.log; then
	exit 0
fi
exit 1

/* test/invaders_tb.sv */
module invaders_tb;

	// Raster position parked outside the visible area between probes
	localparam logic [10:0] OFF_X = 11'd700;
	localparam logic [10:0] OFF_Y = 11'd500;
	localparam string CASE_FILE = "test/game_cases.txt";

	// Character codes used by the case file reader
	localparam int CH_TAB = 9;
	localparam int CH_LF = 10;
	localparam int CH_CR = 13;
	localparam int CH_SPACE = 32;
	localparam int CH_HASH = 35;

	logic clk;
	logic reset;
	logic [10:0] x;
	logic [10:0] y;
	logic btn_left;
	logic btn_right;
	logic btn_fire;
	logic [7:0] sprite_color;
	logic [7:0] rgb;
	logic [1:0] sound;

	int fd;
	int fail_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	invaders_top i_dut (
		.clk(clk),
		.reset(reset),
		.x(x),
		.y(y),
		.btn_left(btn_left),
		.btn_right(btn_right),
		.btn_fire(btn_fire),
		.sprite_color(sprite_color),
		.rgb(rgb),
		.sound(sound)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			fail_count++;
			fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual,
				expected));
		end
	endtask

	// Ends the run if the case file takes far longer than its own length implies
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_limit != 0 && cycle_count > cycle_limit)
			fail_run($sformatf("Timeout after %0d cycles, the cases did not finish", cycle_count));
	end

	// Inputs change one time unit after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic open_cases();
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0)
			fail_run("Could not open the case file test/game_cases.txt");
	endtask

	// Returns the next command letter and its numbers, or zero at the end of the file
	task automatic read_command(output logic [7:0] cmd, output int a0, output int a1,
		output int a2);
		int ch;
		int got;
		a0 = 0;
		a1 = 0;
		a2 = 0;
		got = 0;
		cmd = 8'd0;
		ch = $fgetc(fd);
		// Blank space and comment lines carry no command
		while (ch == CH_SPACE || ch == CH_TAB || ch == CH_LF || ch == CH_CR || ch == CH_HASH)
		begin
			if (ch == CH_HASH)
			begin
				while (ch != CH_LF && ch != -1)
					ch = $fgetc(fd);
			end
			ch = $fgetc(fd);
		end
		if (ch != -1)
		begin
			cmd = ch[7:0];
			case (cmd)
				"F", "S", "C":
				begin
					got = $fscanf(fd, "%h", a0);
					if (got != 1)
						fail_run("A command line in the case file lacks its value");
				end
				"R":
				begin
					got = $fscanf(fd, "%d %h", a0, a1);
					if (got != 2)
						fail_run("A repeat line in the case file lacks its count or mask");
				end
				"P":
				begin
					got = $fscanf(fd, "%d %d %h", a0, a1, a2);
					if (got != 3)
						fail_run("A pixel probe in the case file lacks a value");
				end
				default:
					fail_run("The case file holds an unknown command");
			endcase
		end
	endtask

	// A frame command lasts two cycles, a pixel probe one, the rest none
	function automatic int command_cycles(input logic [7:0] cmd, input int a0);
		int n;
		n = 0;
		if (cmd == "F")
			n = 2;
		else if (cmd == "R")
			n = 2 * a0;
		else if (cmd == "P")
			n = 1;
		return n;
	endfunction

	// Raster origin with the buttons for one cycle, then one cycle off screen
	task automatic apply_frame(input logic [2:0] mask);
		x = 11'd0;
		y = 11'd0;
		btn_left = mask[0];
		btn_right = mask[1];
		btn_fire = mask[2];
		next_cycle();
		x = OFF_X;
		y = OFF_Y;
		btn_left = 1'b0;
		btn_right = 1'b0;
		btn_fire = 1'b0;
		// A fire request launches the bullet on this second edge
		next_cycle();
	endtask

	// The colour for a position shows up one cycle after it is presented
	task automatic probe_pixel(input int px, input int py, input logic [7:0] expected);
		x = px[10:0];
		y = py[10:0];
		next_cycle();
		check_value($sformatf("rgb at %0d,%0d", px, py), 32'(rgb), 32'(expected));
		x = OFF_X;
		y = OFF_Y;
	endtask

	task automatic run_command(input logic [7:0] cmd, input int a0, input int a1,
		input int a2);
		case (cmd)
			"F": apply_frame(a0[2:0]);
			"R":
			begin
				repeat (a0)
					apply_frame(a1[2:0]);
			end
			"P": probe_pixel(a0, a1, a2[7:0]);
			"S": check_value("sound", 32'(sound), a0);
			"C": sprite_color = a0[7:0];
			default: fail_run("The case file holds an unknown command");
		endcase
	endtask

	initial
	begin : main_flow
		int total;
		int a0;
		int a1;
		int a2;
		logic [7:0] cmd;
		reset = 1'b1;
		x = OFF_X;
		y = OFF_Y;
		btn_left = 1'b0;
		btn_right = 1'b0;
		btn_fire = 1'b0;
		sprite_color = 8'h00;

		// First pass only sums the cycles so the timeout fits the case file
		open_cases();
		total = 4;
		read_command(cmd, a0, a1, a2);
		while (cmd != 8'd0)
		begin
			total += command_cycles(cmd, a0);
			read_command(cmd, a0, a1, a2);
		end
		$fclose(fd);
		cycle_limit = 2 * total + 100;

		repeat (4)
			next_cycle();
		reset = 1'b0;

		open_cases();
		read_command(cmd, a0, a1, a2);
		while (cmd != 8'd0)
		begin
			run_command(cmd, a0, a1, a2);
			read_command(cmd, a0, a1, a2);
		end
		$fclose(fd);
		next_cycle();

		if (fail_count == 0)
		begin
			$display("All tests passed");
			$finish;
		end
		else
			fail_run($sformatf("%0d checks did not match", fail_count));
	end

endmodule

/* logic/invaders_top.sv */
module invaders_top import invaders_pkg::*;
#(
	parameter int PLAYER_STEP = 1,
	parameter int MARCH_STEP = 1
)
(
	input logic clk,
	input logic reset,
	input coord_t x,
	input coord_t y,
	input logic btn_left,
	input logic btn_right,
	input logic btn_fire,
	input rgb_t sprite_color,
	output rgb_t rgb,
	output sound_t sound
);

	// One pulse per frame, taken from the raster origin
	logic frame_tick;

	// Ship state
	coord_t player_x;
	logic fire_req;

	// Bullet state
	logic bullet_active;
	coord_t bullet_x;
	coord_t bullet_y;

	// Formation state and the hit outcome of the current frame
	coord_t formation_x;
	logic [INVADER_COUNT-1:0] alive;
	logic [INVADER_COUNT-1:0] wounded;
	logic hit_wound;
	logic hit_kill;

	player_ship #(
		.PLAYER_STEP(PLAYER_STEP)
	) i_player (
		.clk(clk),
		.reset(reset),
		.frame_tick(frame_tick),
		.btn_left(btn_left),
		.btn_right(btn_right),
		.btn_fire(btn_fire),
		.player_x(player_x),
		.fire_req(fire_req)
	);

	bullet_unit i_bullet (
		.clk(clk),
		.reset(reset),
		.frame_tick(frame_tick),
		.fire_req(fire_req),
		.player_x(player_x),
		.hit_wound(hit_wound),
		.hit_kill(hit_kill),
		.bullet_active(bullet_active),
		.bullet_x(bullet_x),
		.bullet_y(bullet_y),
		.sound(sound)
	);

	invader_formation #(
		.MARCH_STEP(MARCH_STEP)
	) i_formation (
		.clk(clk),
		.reset(reset),
		.frame_tick(frame_tick),
		.bullet_active(bullet_active),
		.bullet_x(bullet_x),
		.bullet_y(bullet_y),
		.formation_x(formation_x),
		.alive(alive),
		.wounded(wounded),
		.hit_wound(hit_wound),
		.hit_kill(hit_kill)
	);

	pixel_renderer i_renderer (
		.clk(clk),
		.reset(reset),
		.x(x),
		.y(y),
		.sprite_color(sprite_color),
		.player_x(player_x),
		.bullet_active(bullet_active),
		.bullet_x(bullet_x),
		.bullet_y(bullet_y),
		.formation_x(formation_x),
		.alive(alive),
		.wounded(wounded),
		.frame_tick(frame_tick),
		.rgb(rgb)
	);

endmodule

/* logic/pixel_renderer.sv */
module pixel_renderer import invaders_pkg::*;
(
	input logic clk,
	input logic reset,
	input coord_t x,
	input coord_t y,
	input rgb_t sprite_color,
	input coord_t player_x,
	input logic bullet_active,
	input coord_t bullet_x,
	input coord_t bullet_y,
	input coord_t formation_x,
	input logic [INVADER_COUNT-1:0] alive,
	input logic [INVADER_COUNT-1:0] wounded,
	output logic frame_tick,
	output rgb_t rgb
);

	logic visible;

	logic [1:0] inv_row;
	coord_t inv_dx;
	coord_t inv_dy;
	logic [3:0] inv_col;
	logic [5:0] inv_idx;
	logic [3:0] inv_dot_row;
	logic [3:0] inv_dot_col;
	logic [15:0] inv_bits;
	logic inv_pix;
	rgb_t inv_color;

	coord_t ply_dx;
	coord_t ply_dy;
	logic [3:0] ply_dot_row;
	logic [3:0] ply_dot_col;
	logic [15:0] ply_bits;
	logic ply_pix;

	coord_t blt_dx;
	coord_t blt_dy;
	logic blt_pix;

	// The raster origin marks the start of a new frame
	assign frame_tick = (x == '0) && (y == '0);
	assign visible = (x < SCREEN_W) && (y < SCREEN_H);

	// The invader cell under the raster comes from the row band and the block offset
	assign inv_row = row_at(y);
	assign inv_dx = x - formation_x;
	assign inv_dy = y - row_top(inv_row);
	assign inv_col = 4'(inv_dx / SPRITE_SIZE);
	assign inv_idx = invader_index(inv_row, inv_col);

	// Each stored dot covers 2x2 screen pixels
	assign inv_dot_row = 4'(inv_dy >> 1);
	assign inv_dot_col = 4'((inv_dx % SPRITE_SIZE) >> 1);

	sprite_rom i_invader_rom (
		.sprite(SPRITE_INVADER),
		.row(inv_dot_row),
		.bits(inv_bits)
	);

	// Bit 15 of a pattern row is the leftmost dot
	assign inv_pix = inv_row != NO_ROW && x >= formation_x && inv_dx < FORMATION_W &&
		alive[inv_idx] && inv_bits[4'd15 - inv_dot_col];
	assign inv_color = wounded[inv_idx] ? COLOR_WOUNDED : sprite_color;

	// Ship box is a full 32x32 sprite at the fixed player line
	assign ply_dx = x - player_x;
	assign ply_dy = y - PLAYER_Y;
	assign ply_dot_row = 4'(ply_dy >> 1);
	assign ply_dot_col = 4'(ply_dx >> 1);

	sprite_rom i_player_rom (
		.sprite(SPRITE_PLAYER),
		.row(ply_dot_row),
		.bits(ply_bits)
	);

	assign ply_pix = x >= player_x && ply_dx < SPRITE_SIZE && y >= PLAYER_Y &&
		ply_dy < SPRITE_SIZE && ply_bits[4'd15 - ply_dot_col];

	// Bullet is a plain 4x4 square
	assign blt_dx = x - bullet_x;
	assign blt_dy = y - bullet_y;
	assign blt_pix = bullet_active && x >= bullet_x && blt_dx < BULLET_SIZE &&
		y >= bullet_y && blt_dy < BULLET_SIZE;

	// One register stage tests the highest layer first
	always_ff @(posedge clk)
	begin
		if (reset)
			rgb <= COLOR_NULL;
		else if (!visible)
			rgb <= COLOR_NULL;
		// Bullet and ship both take the sprite colour and sit above the formation
		else if (blt_pix || ply_pix)
			rgb <= sprite_color;
		else if (inv_pix)
			rgb <= inv_color;
		else
			rgb <= COLOR_BACKGROUND;
	end

endmodule

/* logic/invader_formation.sv */
module invader_formation import invaders_pkg::*;
#(
	parameter int MARCH_STEP = 1
)
(
	input logic clk,
	input logic reset,
	input logic frame_tick,
	input logic bullet_active,
	input coord_t bullet_x,
	input coord_t bullet_y,
	output coord_t formation_x,
	output logic [INVADER_COUNT-1:0] alive,
	output logic [INVADER_COUNT-1:0] wounded,
	output logic hit_wound,
	output logic hit_kill
);

	localparam coord_t STEP = coord_t'(MARCH_STEP);

	// Set while the block marches towards the right edge
	logic march_right;

	logic [1:0] hit_row;
	coord_t hit_dx;
	logic [3:0] hit_col;
	logic [5:0] hit_idx;
	logic hit_valid;

	// The row band under the bullet is NO_ROW when it lies between or outside the rows
	assign hit_row = row_at(bullet_y);

	// Column is the bullet offset inside the block in cells of 32 pixels
	assign hit_dx = bullet_x - formation_x;
	assign hit_col = 4'(hit_dx / SPRITE_SIZE);
	assign hit_idx = invader_index(hit_row, hit_col);

	// Dead cells let the bullet through, and the test only counts at the frame tick
	assign hit_valid = frame_tick && bullet_active && hit_row != NO_ROW &&
		bullet_x >= formation_x && hit_dx < FORMATION_W && alive[hit_idx];

	// First hit wounds and a second hit on the same invader kills it
	assign hit_wound = hit_valid && !wounded[hit_idx];
	assign hit_kill = hit_valid && wounded[hit_idx];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			alive <= '1;
			wounded <= '0;
			formation_x <= FORMATION_X_START;
			march_right <= 1'b0;
		end
		else if (frame_tick)
		begin
			if (hit_wound)
				wounded[hit_idx] <= 1'b1;
			if (hit_kill)
				alive[hit_idx] <= 1'b0;

			// Reaching an edge costs one frame in place while the direction turns
			if (!march_right)
			begin
				if (formation_x == '0)
					march_right <= 1'b1;
				else if (formation_x < STEP)
					formation_x <= '0;
				else
					formation_x <= formation_x - STEP;
			end
			else
			begin
				if (formation_x == FORMATION_X_MAX)
					march_right <= 1'b0;
				// Last step is shortened to land exactly on the right edge
				else if (FORMATION_X_MAX - formation_x < STEP)
					formation_x <= FORMATION_X_MAX;
				else
					formation_x <= formation_x + STEP;
			end
		end
	end

	// The whole block stays inside the visible width
	a_formation_on_screen: assert property (@(posedge clk) disable iff (reset)
		formation_x <= FORMATION_X_MAX);

	// One bullet strikes one invader, so a hit frame flips exactly one wounded or alive bit
	a_single_outcome: assert property (@(posedge clk) disable iff (reset)
		(hit_wound || hit_kill) |=>
		$countones({alive ^ $past(alive), wounded ^ $past(wounded)}) == 1);

endmodule

/* logic/bullet_unit.sv */
module bullet_unit import invaders_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic frame_tick,
	input logic fire_req,
	input coord_t player_x,
	input logic hit_wound,
	input logic hit_kill,
	output logic bullet_active,
	output coord_t bullet_x,
	output coord_t bullet_y,
	output sound_t sound
);

	// Flight control and the sound code
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bullet_active <= 1'b0;
			sound <= SOUND_FIRE;
		end
		else
		begin
			if (frame_tick && bullet_active)
			begin
				// A hit in this frame consumes the bullet
				if (hit_wound || hit_kill)
					bullet_active <= 1'b0;
				// Leaves through the top once another step would pass row 0
				else if (bullet_y < BULLET_STEP)
					bullet_active <= 1'b0;
			end
			if (hit_wound)
				sound <= SOUND_WOUND;
			if (hit_kill)
				sound <= SOUND_KILL;
			// Only one bullet may fly, so a request during flight is dropped
			if (fire_req && !bullet_active)
			begin
				bullet_active <= 1'b1;
				sound <= SOUND_FIRE;
			end
		end
	end

	// Position registers are only meaningful while the bullet is active
	always_ff @(posedge clk)
	begin
		if (frame_tick && bullet_active && bullet_y >= BULLET_STEP)
			bullet_y <= bullet_y - BULLET_STEP;
		// fire_req follows the frame tick by one cycle, so the ship has already taken its step
		if (fire_req && !bullet_active)
		begin
			bullet_x <= player_x + MUZZLE_DX;
			bullet_y <= PLAYER_Y - MUZZLE_DY;
		end
	end

	// A hit is only reported for a bullet in flight and it ends that flight on the same edge
	a_hit_needs_bullet: assert property (@(posedge clk) disable iff (reset)
		(hit_wound || hit_kill) |=> $past(bullet_active) && !bullet_active);

endmodule

/* logic/player_ship.sv */
module player_ship import invaders_pkg::*;
#(
	parameter int PLAYER_STEP = 1
)
(
	input logic clk,
	input logic reset,
	input logic frame_tick,
	input logic btn_left,
	input logic btn_right,
	input logic btn_fire,
	output coord_t player_x,
	output logic fire_req
);

	localparam coord_t STEP = coord_t'(PLAYER_STEP);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			player_x <= PLAYER_X_START;
			fire_req <= 1'b0;
		end
		else
		begin
			// The fire button is sampled once per frame and handed on as a single pulse
			fire_req <= frame_tick && btn_fire;
			if (frame_tick)
			begin
				// Left keeps the ship clear of column 0
				if (btn_left && player_x > STEP)
					player_x <= player_x - STEP;
				// Right is tested second, so it wins when both buttons are held
				if (btn_right && player_x < PLAYER_X_MAX)
				begin
					// A step larger than the gap lands the ship on the right edge
					if (PLAYER_X_MAX - player_x < STEP)
						player_x <= PLAYER_X_MAX;
					else
						player_x <= player_x + STEP;
				end
			end
		end
	end

	// The ship is 32 pixels wide and must stay on screen
	a_player_on_screen: assert property (@(posedge clk) disable iff (reset)
		player_x <= PLAYER_X_MAX);

endmodule

/* logic/sprite_rom.sv */
module sprite_rom import invaders_pkg::*;
(
	input logic sprite,
	input logic [3:0] row,
	output logic [15:0] bits
);

	// Invader pattern in words 0 to 15, player pattern in words 16 to 31
	logic [SPRITE_DOTS-1:0] patterns [0:2*SPRITE_DOTS-1];

	initial
	begin
		$readmemh("logic/sprites.hex", patterns);
	end

	// Sprite select is the top address bit
	assign bits = patterns[{sprite, row}];

endmodule

/* logic/invaders_pkg.sv */
package invaders_pkg;

	// Screen positions and object coordinates share one width
	typedef logic [10:0] coord_t;
	typedef logic [7:0] rgb_t;

	// Code 1 is unused, the sound block decodes only these three
	typedef enum logic [1:0]
	{
		SOUND_FIRE  = 2'd0,
		SOUND_WOUND = 2'd2,
		SOUND_KILL  = 2'd3
	} sound_t;

	// Visible area of the raster
	localparam coord_t SCREEN_W = 11'd640;
	localparam coord_t SCREEN_H = 11'd480;

	// A sprite is stored as 16x16 dots and drawn with every dot doubled
	localparam coord_t SPRITE_SIZE = 11'd32;
	localparam int SPRITE_DOTS = 16;

	// Formation of 3 rows by 11 columns, one bit per invader, row 0 first
	localparam int INVADER_ROWS = 3;
	localparam int INVADER_COLS = 11;
	localparam int INVADER_COUNT = INVADER_ROWS * INVADER_COLS;
	localparam coord_t ROW_HEIGHT = 11'd30;
	localparam coord_t FORMATION_W = coord_t'(INVADER_COLS) * SPRITE_SIZE;
	localparam coord_t FORMATION_X_START = 11'd128;
	localparam coord_t FORMATION_X_MAX = SCREEN_W - FORMATION_W;
	localparam coord_t ROW_Y_FIRST = 11'd64;
	localparam coord_t ROW_PITCH = 11'd32;

	// Row code returned when a line lies in no invader band
	localparam logic [1:0] NO_ROW = 2'd3;

	// Player ship and its single bullet
	localparam coord_t PLAYER_Y = 11'd416;
	localparam coord_t PLAYER_X_START = 11'd320;
	localparam coord_t PLAYER_X_MAX = 11'd608;
	localparam coord_t BULLET_SIZE = 11'd4;
	localparam coord_t BULLET_STEP = 11'd4;
	localparam coord_t MUZZLE_DX = 11'd14;
	localparam coord_t MUZZLE_DY = 11'd8;

	localparam rgb_t COLOR_BACKGROUND = 8'h48;
	localparam rgb_t COLOR_WOUNDED = 8'h3C;
	localparam rgb_t COLOR_NULL = 8'h00;

	// Pattern select into the sprite ROM
	localparam logic SPRITE_INVADER = 1'b0;
	localparam logic SPRITE_PLAYER = 1'b1;

	// Top line of an invader row
	function automatic coord_t row_top(logic [1:0] row);
		return ROW_Y_FIRST + ROW_PITCH * coord_t'(row);
	endfunction

	// Finds the row whose inclusive band holds ypos, bands never overlap
	function automatic logic [1:0] row_at(coord_t ypos);
		logic [1:0] row;
		row = NO_ROW;
		for (int r = 0; r < INVADER_ROWS; r++)
		begin
			if (ypos >= row_top(2'(r)) && ypos <= row_top(2'(r)) + ROW_HEIGHT)
				row = 2'(r);
		end
		return row;
	endfunction

	// Bit position of invader (row, col) in the row-major state vectors
	function automatic logic [5:0] invader_index(logic [1:0] row, logic [3:0] col);
		return 6'(row * INVADER_COLS + col);
	endfunction

endpackage
